// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/1ps
TOP       = tb_core_shell
RTL_TOP   = core_shell
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	rm -f $(LOG)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
verilog/shell_pkg.sv
verilog/bridge_regs.sv
verilog/palette_loader.sv
verilog/ff_control.sv
verilog/video_out.sv
verilog/core_shell.sv
tests/shell_checker.sv
tests/tb_core_shell.sv

// File: tests/shell_checker.sv
`timescale 1ns/1ps
`default_nettype none

module shell_checker #(
    parameter int RESET_DELAY_CYCLES = 64,
    parameter int FF_TAP_CYCLES      = 100,
    parameter int HS_DELAY           = 7
) (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  shell_pkg::bridge_req_t  bridge,
    input  logic [31:0]             bridge_rd_data,
    input  shell_pkg::slot_ctl_t    slot,
    input  logic [31:0]             cont1_key,
    input  shell_pkg::audio_t       core_audio,
    input  shell_pkg::lcd_pix_t     lcd,
    input  logic                    core_reset,
    input  shell_pkg::settings_t    settings,
    input  shell_pkg::palette_t     palette,
    input  logic                    fast_forward,
    input  shell_pkg::audio_t       audio,
    input  shell_pkg::video_t       video,
    output int                      error_count,
    output int                      check_count
);

    int errors = 0;
    int checks = 0;

    // model state, always the value before the coming edge
    shell_pkg::settings_t exp_settings;
    int                   reset_left;
    logic                 dl_active;
    logic [15:0]          dl_slot;
    logic [127:0]         exp_palette;
    logic                 req;
    logic                 req_prev;
    logic                 tap_latch;
    logic                 last_tap_latched;
    int                   hold_len;
    logic                 exp_ff;
    shell_pkg::audio_t    exp_audio;
    logic                 exp_de;
    logic                 exp_vs;
    logic                 exp_hs;
    logic                 vs_in_prev;
    logic                 hs_in_prev;
    int                   hs_age;
    shell_pkg::rgb_t      exp_rgb;

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic [7:0] luma(shell_pkg::rgb_t p);
        int sum;
        sum = p.r / 4 + p.r / 32 + p.g / 2 + p.g / 16 + p.b / 16 + p.b / 32;
        return 8'(sum);
    endfunction

    function automatic logic is_core_slot(logic [15:0] id);
        return id == shell_pkg::SLOT_CART || id == shell_pkg::SLOT_BOOT_CGB ||
               id == shell_pkg::SLOT_BOOT_DMG || id == shell_pkg::SLOT_BOOT_SGB;
    endfunction

    function automatic logic [31:0] readback_value(logic [31:0] addr);
        case (addr)
            shell_pkg::ADDR_RESET:  return 32'(reset_left);
            shell_pkg::ADDR_RUMBLE: return 32'(exp_settings.rumble_en);
            shell_pkg::ADDR_COLORS: return 32'(exp_settings.original_colors);
            shell_pkg::ADDR_FF:     return 32'(exp_settings.ff_en);
            shell_pkg::ADDR_FF_SND: return 32'(exp_settings.ff_snd_en);
            shell_pkg::ADDR_TINT:   return 32'(exp_settings.tint);
            shell_pkg::ADDR_BW:     return 32'(exp_settings.bw_en);
            default:                return 32'd0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reset_model();
        exp_settings     = '0;
        reset_left       = 0;
        dl_active        = 1'b0;
        dl_slot          = '0;
        exp_palette      = shell_pkg::DEFAULT_PALETTE;
        req              = 1'b0;
        req_prev         = 1'b0;
        tap_latch        = 1'b0;
        last_tap_latched = 1'b0;
        hold_len         = 0;
        exp_ff           = 1'b0;
        exp_audio        = '0;
        exp_de           = 1'b0;
        exp_vs           = 1'b0;
        exp_hs           = 1'b0;
        vs_in_prev       = 1'b0;
        hs_in_prev       = 1'b0;
        hs_age           = 1000;
        exp_rgb          = '0;
    endtask

    ////////////////////////////////////////
    // comparison of every output
    ////////////////////////////////////////

    task automatic check_outputs();
        logic [7:0]  y;
        logic [23:0] exp_pix;
        logic        exp_core_reset;
        y = luma(exp_rgb);
        if (exp_settings.bw_en) begin
            exp_pix = {y, y, y};
        end else begin
            exp_pix = exp_rgb;
        end
        exp_core_reset = (reset_left != 0) || (dl_active && is_core_slot(dl_slot));
        compare_value("bridge_rd_data", 128'(readback_value(bridge.addr)),
                      128'(bridge_rd_data));
        compare_value("core_reset", 128'(exp_core_reset), 128'(core_reset));
        compare_value("settings", 128'(exp_settings), 128'(settings));
        compare_value("palette", exp_palette, palette);
        compare_value("fast_forward", 128'(exp_ff), 128'(fast_forward));
        compare_value("audio", 128'(exp_audio), 128'(audio));
        compare_value("video.de", 128'(exp_de), 128'(video.de));
        compare_value("video.vs", 128'(exp_vs), 128'(video.vs));
        compare_value("video.hs", 128'(exp_hs), 128'(video.hs));
        compare_value("video.rgb", 128'(exp_pix), 128'(video.rgb));
    endtask

    ////////////////////////////////////////
    // model step at each clock edge
    ////////////////////////////////////////

    task automatic advance_model();
        // fast forward first, it reads the old settings and download state
        if (exp_ff && !exp_settings.ff_snd_en) begin
            exp_audio = '0;
        end else begin
            exp_audio = core_audio;
        end
        exp_ff = req || tap_latch;
        if (req && !req_prev) begin
            tap_latch = 1'b0;
            hold_len  = 0;
        end else if (req) begin
            hold_len++;
        end
        if (!req && req_prev) begin
            if (hold_len < FF_TAP_CYCLES && !last_tap_latched) begin
                tap_latch        = 1'b1;
                last_tap_latched = 1'b1;
            end else begin
                last_tap_latched = 1'b0;
            end
        end
        req_prev = req;
        req = exp_settings.ff_en && cont1_key[shell_pkg::FF_KEY_BIT] && !dl_active;

        if (bridge.wr && bridge.addr == shell_pkg::ADDR_RESET) begin
            reset_left = RESET_DELAY_CYCLES;
        end else if (reset_left > 0) begin
            reset_left--;
        end
        if (bridge.wr) begin
            case (bridge.addr)
                shell_pkg::ADDR_RUMBLE: exp_settings.rumble_en = bridge.wr_data[0];
                shell_pkg::ADDR_COLORS: exp_settings.original_colors = bridge.wr_data[0];
                shell_pkg::ADDR_FF:     exp_settings.ff_en = bridge.wr_data[0];
                shell_pkg::ADDR_FF_SND: exp_settings.ff_snd_en = bridge.wr_data[0];
                shell_pkg::ADDR_TINT:   exp_settings.tint = bridge.wr_data[1:0];
                shell_pkg::ADDR_BW:     exp_settings.bw_en = bridge.wr_data[0];
                default: ;
            endcase
        end

        // palette words enter low byte first
        if (dl_active && dl_slot == shell_pkg::SLOT_PALETTE && slot.loader_wr) begin
            exp_palette = {exp_palette[111:0], slot.loader_data[7:0], slot.loader_data[15:8]};
        end
        if (slot.request_write) begin
            dl_active = 1'b1;
            dl_slot   = slot.request_write_id;
        end else if (slot.all_complete) begin
            dl_active = 1'b0;
        end

        // hs pulse when the last rise is HS_DELAY edges old
        exp_hs = (hs_age == HS_DELAY - 1);
        if (lcd.hs && !hs_in_prev) begin
            hs_age = 0;
        end else if (hs_age < 1000) begin
            hs_age++;
        end
        hs_in_prev = lcd.hs;
        exp_vs     = lcd.vs && !vs_in_prev;
        vs_in_prev = lcd.vs;
        exp_de     = !(lcd.hblank || lcd.vblank);
        exp_rgb    = exp_de ? lcd.rgb : '0;
    endtask

    initial begin
        reset_model();
    end

    // outputs read here still hold their values from before the edge
    always @(posedge clk_sys) begin
        if (rst) begin
            reset_model();
        end else begin
            check_outputs();
            advance_model();
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_core_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_shell;

    localparam int RESET_DELAY_CYCLES = 64;
    localparam int FF_TAP_CYCLES      = 100;
    localparam int HS_DELAY           = 7;
    localparam int CLK_PERIOD         = 8;
    localparam int RESET_CYCLES       = 3;
    localparam int STIM_CYCLES        = 8000;
    localparam int SEED               = 39582;
    localparam int WATCHDOG_NS        = (RESET_CYCLES + STIM_CYCLES + 200) * CLK_PERIOD;

    logic                   clk_sys;
    logic                   rst;
    shell_pkg::bridge_req_t bridge;
    logic [31:0]            bridge_rd_data;
    shell_pkg::slot_ctl_t   slot;
    logic [31:0]            cont1_key;
    shell_pkg::audio_t      core_audio;
    shell_pkg::lcd_pix_t    lcd;
    logic                   core_reset;
    shell_pkg::settings_t   settings;
    shell_pkg::palette_t    palette;
    logic                   fast_forward;
    shell_pkg::audio_t      audio;
    shell_pkg::video_t      video;
    int                     error_count;
    int                     check_count;

    // stimulus side state only
    int   key_left;
    logic dl_busy;

    core_shell #(
        .RESET_DELAY_CYCLES (RESET_DELAY_CYCLES),
        .FF_TAP_CYCLES      (FF_TAP_CYCLES),
        .HS_DELAY           (HS_DELAY)
    ) dut_i (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .slot           (slot),
        .cont1_key      (cont1_key),
        .core_audio     (core_audio),
        .lcd            (lcd),
        .core_reset     (core_reset),
        .settings       (settings),
        .palette        (palette),
        .fast_forward   (fast_forward),
        .audio          (audio),
        .video          (video)
    );

    shell_checker #(
        .RESET_DELAY_CYCLES (RESET_DELAY_CYCLES),
        .FF_TAP_CYCLES      (FF_TAP_CYCLES),
        .HS_DELAY           (HS_DELAY)
    ) shell_checker_i (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .bridge         (bridge),
        .bridge_rd_data (bridge_rd_data),
        .slot           (slot),
        .cont1_key      (cont1_key),
        .core_audio     (core_audio),
        .lcd            (lcd),
        .core_reset     (core_reset),
        .settings       (settings),
        .palette        (palette),
        .fast_forward   (fast_forward),
        .audio          (audio),
        .video          (video),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    ////////////////////////////////////////
    // random stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] choose_address();
        int pick;
        pick = int'($urandom % 10);
        case (pick)
            0: return shell_pkg::ADDR_RESET;
            1: return shell_pkg::ADDR_RUMBLE;
            2: return shell_pkg::ADDR_COLORS;
            3: return shell_pkg::ADDR_FF;
            4: return shell_pkg::ADDR_FF_SND;
            5: return shell_pkg::ADDR_TINT;
            6: return shell_pkg::ADDR_BW;
            default: return {20'd0, 10'($urandom), 2'b00};
        endcase
    endfunction

    // palette slot weighted up, id 2 stands for a slot nobody decodes
    function automatic logic [15:0] slot_id_from_table();
        int pick;
        pick = int'($urandom % 8);
        case (pick)
            0: return shell_pkg::SLOT_CART;
            1, 2, 3: return shell_pkg::SLOT_PALETTE;
            4: return shell_pkg::SLOT_BOOT_CGB;
            5: return shell_pkg::SLOT_BOOT_DMG;
            6: return shell_pkg::SLOT_BOOT_SGB;
            default: return 16'd2;
        endcase
    endfunction

    task automatic issue_bus_cycle();
        bridge.addr    = choose_address();
        bridge.wr_data = $urandom;
        // reset writes kept rare so the countdown is not always running
        bridge.wr = ($urandom % 8 == 0) &&
                    (bridge.addr != shell_pkg::ADDR_RESET || $urandom % 4 == 0);
        bridge.rd = !bridge.wr && ($urandom % 3 == 0);
    endtask

    task automatic post_slot_event();
        slot = '0;
        if (!dl_busy && $urandom % 150 == 0) begin
            slot.request_write    = 1'b1;
            slot.request_write_id = slot_id_from_table();
            dl_busy = 1'b1;
        end else if (dl_busy && $urandom % 50 == 0) begin
            slot.all_complete = 1'b1;
            dl_busy = 1'b0;
        end
        slot.loader_wr   = ($urandom % 3 == 0);
        slot.loader_data = 16'($urandom);
    endtask

    // short taps stay well below the limit, long holds well above
    task automatic hold_keys();
        if (key_left == 0 && $urandom % 40 == 0) begin
            if ($urandom % 2 == 0) begin
                key_left = 1 + int'($urandom % (FF_TAP_CYCLES - 10));
            end else begin
                key_left = FF_TAP_CYCLES + 5 + int'($urandom % 150);
            end
        end
        cont1_key = $urandom;
        cont1_key[shell_pkg::FF_KEY_BIT] = (key_left > 0);
        if (key_left > 0) begin
            key_left--;
        end
    endtask

    task automatic stream_lcd();
        if ($urandom % 10 == 0) lcd.hblank = !lcd.hblank;
        if ($urandom % 60 == 0) lcd.vblank = !lcd.vblank;
        if ($urandom % 6 == 0) lcd.hs = !lcd.hs;
        if ($urandom % 40 == 0) lcd.vs = !lcd.vs;
        lcd.rgb = 24'($urandom);
    endtask

    ////////////////////////////////////////
    // clock, stimulus and watchdog
    ////////////////////////////////////////

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        bridge     = '0;
        slot       = '0;
        cont1_key  = '0;
        core_audio = '0;
        lcd        = '0;
        key_left   = 0;
        dl_busy    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            issue_bus_cycle();
            post_slot_event();
            hold_keys();
            stream_lcd();
            core_audio = $urandom;
            @(negedge clk_sys);
        end
        // let the checker see the last driven cycle
        repeat (2) @(negedge clk_sys);
        $display("closing: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bridge_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_regs #(
    parameter int RESET_DELAY_CYCLES = 64
) (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  shell_pkg::bridge_req_t  bridge,
    output logic [31:0]             bridge_rd_data,
    input  shell_pkg::slot_ctl_t    slot,
    output shell_pkg::settings_t    settings,
    output logic                    download_active,
    output logic [15:0]             download_slot,
    output logic                    core_reset
);

    localparam int CNT_W = $clog2(RESET_DELAY_CYCLES + 1);

    logic [CNT_W-1:0] reset_count;
    logic             core_download;

    ////////////////////////////////////////
    // settings writes and reset countdown
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings    <= '0;
            reset_count <= '0;
        end else begin
            if (reset_count != '0) begin
                reset_count <= reset_count - 1'b1;
            end
            if (bridge.wr) begin
                case (bridge.addr)
                    shell_pkg::ADDR_RESET:  reset_count <= CNT_W'(RESET_DELAY_CYCLES);
                    shell_pkg::ADDR_RUMBLE: settings.rumble_en <= bridge.wr_data[0];
                    shell_pkg::ADDR_COLORS: settings.original_colors <= bridge.wr_data[0];
                    shell_pkg::ADDR_FF:     settings.ff_en <= bridge.wr_data[0];
                    shell_pkg::ADDR_FF_SND: settings.ff_snd_en <= bridge.wr_data[0];
                    shell_pkg::ADDR_TINT:   settings.tint <= bridge.wr_data[1:0];
                    shell_pkg::ADDR_BW:     settings.bw_en <= bridge.wr_data[0];
                    default: ;
                endcase
            end
        end
    end

    // readback straight from the address, no wait state
    always_comb begin
        case (bridge.addr)
            shell_pkg::ADDR_RESET:  bridge_rd_data = 32'(reset_count);
            shell_pkg::ADDR_RUMBLE: bridge_rd_data = {31'd0, settings.rumble_en};
            shell_pkg::ADDR_COLORS: bridge_rd_data = {31'd0, settings.original_colors};
            shell_pkg::ADDR_FF:     bridge_rd_data = {31'd0, settings.ff_en};
            shell_pkg::ADDR_FF_SND: bridge_rd_data = {31'd0, settings.ff_snd_en};
            shell_pkg::ADDR_TINT:   bridge_rd_data = {30'd0, settings.tint};
            shell_pkg::ADDR_BW:     bridge_rd_data = {31'd0, settings.bw_en};
            default:                bridge_rd_data = 32'd0;
        endcase
    end

    ////////////////////////////////////////
    // download tracking
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            download_active <= 1'b0;
            download_slot   <= '0;
        end else if (slot.request_write) begin
            download_active <= 1'b1;
            download_slot   <= slot.request_write_id;
        end else if (slot.all_complete) begin
            download_active <= 1'b0;
        end
    end

    // cart and boot images hold the core in reset while they load
    assign core_download = download_active &&
                           (download_slot == shell_pkg::SLOT_CART ||
                            download_slot == shell_pkg::SLOT_BOOT_CGB ||
                            download_slot == shell_pkg::SLOT_BOOT_DMG ||
                            download_slot == shell_pkg::SLOT_BOOT_SGB);

    assign core_reset = (reset_count != '0) || core_download;

endmodule

`default_nettype wire

// File: verilog/core_shell.sv
`timescale 1ns/1ps
`default_nettype none

module core_shell #(
    parameter int RESET_DELAY_CYCLES = 64,
    parameter int FF_TAP_CYCLES      = 100,
    parameter int HS_DELAY           = 7
) (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  shell_pkg::bridge_req_t  bridge,
    output logic [31:0]             bridge_rd_data,
    input  shell_pkg::slot_ctl_t    slot,
    input  logic [31:0]             cont1_key,
    input  shell_pkg::audio_t       core_audio,
    input  shell_pkg::lcd_pix_t     lcd,
    output logic                    core_reset,
    output shell_pkg::settings_t    settings,
    output shell_pkg::palette_t     palette,
    output logic                    fast_forward,
    output shell_pkg::audio_t       audio,
    output shell_pkg::video_t       video
);

    logic        download_active;
    logic [15:0] download_slot;

    bridge_regs #(
        .RESET_DELAY_CYCLES (RESET_DELAY_CYCLES)
    ) bridge_regs_i (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .bridge          (bridge),
        .bridge_rd_data  (bridge_rd_data),
        .slot            (slot),
        .settings        (settings),
        .download_active (download_active),
        .download_slot   (download_slot),
        .core_reset      (core_reset)
    );

    palette_loader palette_loader_i (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .slot            (slot),
        .download_active (download_active),
        .download_slot   (download_slot),
        .palette         (palette)
    );

    ff_control #(
        .FF_TAP_CYCLES (FF_TAP_CYCLES)
    ) ff_control_i (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .settings        (settings),
        .download_active (download_active),
        .keys            (cont1_key),
        .audio_in        (core_audio),
        .fast_forward    (fast_forward),
        .audio_out       (audio)
    );

    video_out #(
        .HS_DELAY (HS_DELAY)
    ) video_out_i (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .settings (settings),
        .lcd      (lcd),
        .video    (video)
    );

endmodule

`default_nettype wire

// File: verilog/ff_control.sv
`timescale 1ns/1ps
`default_nettype none

module ff_control #(
    parameter int FF_TAP_CYCLES = 100
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  shell_pkg::settings_t  settings,
    input  logic                  download_active,
    input  logic [31:0]           keys,
    input  shell_pkg::audio_t     audio_in,
    output logic                  fast_forward,
    output shell_pkg::audio_t     audio_out
);

    localparam int CNT_W = $clog2(FF_TAP_CYCLES + 1);

    logic             ff_req;
    logic             ff_req_prev;
    logic             ff_latch;
    logic             ff_was_held;
    logic [CNT_W-1:0] hold_count;

    ////////////////////////////////////////
    // request, hold count and tap latch
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ff_req       <= 1'b0;
            ff_req_prev  <= 1'b0;
            ff_latch     <= 1'b0;
            ff_was_held  <= 1'b0;
            hold_count   <= '0;
            fast_forward <= 1'b0;
        end else begin
            ff_req      <= settings.ff_en && keys[shell_pkg::FF_KEY_BIT] && !download_active;
            ff_req_prev <= ff_req;

            // saturate so a long hold never wraps back under the tap limit
            if (ff_req && hold_count != CNT_W'(FF_TAP_CYCLES)) begin
                hold_count <= hold_count + 1'b1;
            end

            if (ff_req && !ff_req_prev) begin
                ff_latch   <= 1'b0;
                hold_count <= '0;
            end

            // short tap latches, the next tap releases
            if (!ff_req && ff_req_prev) begin
                ff_was_held <= 1'b0;
                if (hold_count < CNT_W'(FF_TAP_CYCLES) && !ff_was_held) begin
                    ff_was_held <= 1'b1;
                    ff_latch    <= 1'b1;
                end
            end

            fast_forward <= ff_req || ff_latch;
        end
    end

    ////////////////////////////////////////
    // audio mute
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            audio_out <= '0;
        end else if (fast_forward && !settings.ff_snd_en) begin
            audio_out <= '0;
        end else begin
            audio_out <= audio_in;
        end
    end

endmodule

`default_nettype wire

// File: verilog/palette_loader.sv
`timescale 1ns/1ps
`default_nettype none

module palette_loader (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  shell_pkg::slot_ctl_t  slot,
    input  logic                  download_active,
    input  logic [15:0]           download_slot,
    output shell_pkg::palette_t   palette
);

    logic        palette_wr;
    logic [15:0] swapped_word;

    ////////////////////////////////////////
    // slot decode
    ////////////////////////////////////////

    assign palette_wr = download_active &&
                        (download_slot == shell_pkg::SLOT_PALETTE) &&
                        slot.loader_wr;

    // download words arrive big endian per colour byte pair
    assign swapped_word = {slot.loader_data[7:0], slot.loader_data[15:8]};

    ////////////////////////////////////////
    // palette shift register
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            palette <= shell_pkg::DEFAULT_PALETTE;
        end else if (palette_wr) begin
            // oldest word ends up in colour 1
            palette <= {palette[111:0], swapped_word};
        end
    end

endmodule

`default_nettype wire

// File: verilog/shell_pkg.sv
`default_nettype none

package shell_pkg;

    ////////////////////////////////////////
    // bus and slot types
    ////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    typedef struct packed {
        logic       rumble_en;
        logic       original_colors;
        logic       ff_en;
        logic       ff_snd_en;
        logic       bw_en;
        logic [1:0] tint;
    } settings_t;

    typedef struct packed {
        logic        request_write;
        logic [15:0] request_write_id;
        logic        all_complete;
        logic        loader_wr;
        logic [15:0] loader_data;
    } slot_ctl_t;

    ////////////////////////////////////////
    // pixel and sample types
    ////////////////////////////////////////

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // colour 1 sits in the top bits, tail matches the 128-bit download
    typedef struct packed {
        rgb_t        col1;
        rgb_t        col2;
        rgb_t        col3;
        rgb_t        col4;
        logic [31:0] tail;
    } palette_t;

    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } lcd_pix_t;

    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hs;
        logic vs;
    } video_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } audio_t;

    ////////////////////////////////////////
    // constants
    ////////////////////////////////////////

    localparam logic [31:0] ADDR_RESET  = 32'h050;
    localparam logic [31:0] ADDR_RUMBLE = 32'h204;
    localparam logic [31:0] ADDR_COLORS = 32'h208;
    localparam logic [31:0] ADDR_FF     = 32'h20C;
    localparam logic [31:0] ADDR_FF_SND = 32'h210;
    localparam logic [31:0] ADDR_TINT   = 32'h214;
    localparam logic [31:0] ADDR_BW     = 32'h218;

    localparam logic [15:0] SLOT_CART     = 16'd1;
    localparam logic [15:0] SLOT_PALETTE  = 16'd3;
    localparam logic [15:0] SLOT_BOOT_CGB = 16'd4;
    localparam logic [15:0] SLOT_BOOT_DMG = 16'd5;
    localparam logic [15:0] SLOT_BOOT_SGB = 16'd6;

    localparam logic [127:0] DEFAULT_PALETTE = 128'h828214517356305A5F1A3B4900000000;

    // right shoulder button in the controller key word
    localparam int FF_KEY_BIT = 9;

endpackage

`default_nettype wire

// File: verilog/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out #(
    parameter int HS_DELAY = 7
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  shell_pkg::settings_t  settings,
    input  shell_pkg::lcd_pix_t   lcd,
    output shell_pkg::video_t     video
);

    localparam int DLY_W = $clog2(HS_DELAY + 1);

    logic             de;
    logic             de_reg;
    logic             hs_reg;
    logic             vs_reg;
    logic             hs_prev;
    logic             vs_prev;
    logic [DLY_W-1:0] hs_delay;
    shell_pkg::rgb_t  rgb_reg;
    logic [7:0]       lum;

    assign de = !(lcd.hblank || lcd.vblank);

    ////////////////////////////////////////
    // pixel and sync registers
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            de_reg   <= 1'b0;
            hs_reg   <= 1'b0;
            vs_reg   <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_delay <= '0;
            rgb_reg  <= '0;
        end else begin
            de_reg  <= de;
            // black outside the active area
            rgb_reg <= de ? lcd.rgb : '0;

            // single vs pulse on the rising edge of the core vsync
            vs_reg  <= lcd.vs && !vs_prev;
            vs_prev <= lcd.vs;
            hs_prev <= lcd.hs;

            // hs held back so it never lands on the vs pulse
            hs_reg <= (hs_delay == DLY_W'(1));
            if (hs_delay != '0) begin
                hs_delay <= hs_delay - 1'b1;
            end
            if (lcd.hs && !hs_prev) begin
                hs_delay <= DLY_W'(HS_DELAY);
            end
        end
    end

    ////////////////////////////////////////
    // greyscale
    ////////////////////////////////////////

    // approx 0.28 r + 0.56 g + 0.09 b, wraps in 8 bits
    assign lum = (rgb_reg.r >> 2) + (rgb_reg.r >> 5) +
                 (rgb_reg.g >> 1) + (rgb_reg.g >> 4) +
                 (rgb_reg.b >> 4) + (rgb_reg.b >> 5);

    always_comb begin
        video.de = de_reg;
        video.hs = hs_reg;
        video.vs = vs_reg;
        if (settings.bw_en) begin
            video.rgb = {lum, lum, lum};
        end else begin
            video.rgb = rgb_reg;
        end
    end

endmodule

`default_nettype wire
